// File: design/trace_consts.svh
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

// Datapath widths
`define XLEN       32
`define ORDER_W    64
`define REG_COUNT  32

// Number of machine CSRs carried in the trace
`define CSR_COUNT  8

////////////////////////////////////////////////////////////////////////////
// CSR slot positions in csrObs and csrState
////////////////////////////////////////////////////////////////////////////
`define CSR_MSTATUS   0
`define CSR_MIE       1
`define CSR_MTVEC     2
`define CSR_MSCRATCH  3
`define CSR_MEPC      4
`define CSR_MCAUSE    5
`define CSR_MTVAL     6
`define CSR_MIP       7

// Implemented interrupt lines
// MSI 3, MTI 7, MEI 11, local 16 to 31
`define IRQ_MASK  32'hFFFF_0888

// NMI causes for data bus errors
`define NMI_LOAD_CAUSE   11'd1024
`define NMI_STORE_CAUSE  11'd1025

// Exception code of an instruction fetch bus error
`define FETCH_FAULT_CAUSE  6'd48

`endif

// File: design/tracePkg.sv
`include "trace_consts.svh"

package tracePkg;

   // Plain vectors
   typedef logic [`XLEN-1:0]      word_t;
   typedef logic [`ORDER_W-1:0]   order_t;
   typedef logic [4:0]            regAddr_t;
   typedef logic [`REG_COUNT-1:0] regMask_t;
   typedef logic [`CSR_COUNT-1:0] csrMask_t;
   typedef logic [31:0]           irqVec_t;
   typedef logic [10:0]           intrCause_t;
   typedef logic [5:0]            excCause_t;

   // Trap and interrupt side bands of a retirement
   typedef struct packed {
      logic      trap;
      logic      exception;
      excCause_t excCause;
   } trapInfo_t;

   typedef struct packed {
      logic       intr;
      logic       interrupt;
      intrCause_t cause;
   } intrInfo_t;

   ////////////////////////////////////////////////////////////////////////////
   // Formal interface record, one per retired instruction
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic      valid;
      order_t    order;
      word_t     insn;
      word_t     pcRdata;
      word_t     pcWdata;
      trapInfo_t trap;
      intrInfo_t intr;
      logic      nmiPending;
      regAddr_t  rdAddr;
      word_t     rdData;
   } rvfiRecord_t;

   // One observed CSR
   typedef struct packed {
      word_t rdata;
      word_t wdata;
      word_t wmask;
   } csrObs_t;

   typedef csrObs_t [`CSR_COUNT-1:0] csrObsVec_t;
   typedef word_t   [`CSR_COUNT-1:0] csrValueVec_t;

   ////////////////////////////////////////////////////////////////////////////
   // Verification interface side
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic      valid;
      order_t    order;
      word_t     insn;
      word_t     pcRdata;
      word_t     pcWdata;
      trapInfo_t trap;
      intrInfo_t intr;
      regMask_t  regWriteMask;
      word_t     regWriteData;
   } traceRecord_t;

   // Asynchronous net levels
   typedef struct packed {
      logic       haltReq;
      irqVec_t    irq;
      logic       nmi;
      intrCause_t nmiCause;
      logic       busFault;
   } netState_t;

   // One cycle change markers for the nets
   typedef struct packed {
      logic    haltReq;
      irqVec_t irq;
      logic    nmi;
      logic    busFault;
   } netChange_t;

endpackage

// File: design/retireCapture.sv
`timescale 1ns/1ps

module retireCapture import tracePkg::*; (
   input  logic         rvvi,
   input  logic         reset,
   input  rvfiRecord_t  retire,
   output traceRecord_t trace
);

   regMask_t writeMask;
   word_t    writeData;

   // One-hot destination decode
   // x0 never shows as written
   always_comb begin
      writeMask = '0;
      writeData = '0;
      if (retire.valid && (retire.rdAddr != '0)) begin
         writeMask[retire.rdAddr] = 1'b1;
         writeData = retire.rdData;
      end
   end

   // Record registered every cycle
   // Valid follows the strobe one cycle later
   always_ff @(posedge rvvi) begin
      if (reset) begin
         trace <= '0;
      end else begin
         trace.valid        <= retire.valid;
         trace.order        <= retire.order;
         trace.insn         <= retire.insn;
         trace.pcRdata      <= retire.pcRdata;
         trace.pcWdata      <= retire.pcWdata;
         trace.trap         <= retire.trap;
         trace.intr         <= retire.intr;
         trace.regWriteMask <= writeMask;
         trace.regWriteData <= writeData;
      end
   end

endmodule

// File: design/csrMerge.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module csrMerge import tracePkg::*; (
   input  logic         rvvi,
   input  logic         reset,
   input  rvfiRecord_t  retire,
   input  csrObsVec_t   csrObs,
   output csrValueVec_t csrState,
   output csrMask_t     csrWritten
);

   csrValueVec_t merged;
   csrMask_t     differs;

   ////////////////////////////////////////////////////////////////////////////
   // Merge per slot
   ////////////////////////////////////////////////////////////////////////////
   // Written bits come from wdata
   // Untouched bits keep the value read before the instruction
   always_comb begin
      for (int i = 0; i < `CSR_COUNT; i++) begin
         merged[i] = (csrObs[i].wdata & csrObs[i].wmask) |
                     (csrObs[i].rdata & ~csrObs[i].wmask);
         // Compare against the value already published
         differs[i] = (merged[i] != csrState[i]);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // State and write flags
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (reset) begin
         csrState   <= '0;
         csrWritten <= '0;
      end else if (retire.valid) begin
         csrState   <= merged;
         // Only slots whose value moved
         csrWritten <= differs;
      end else begin
         // Values hold between retires
         csrWritten <= '0;
      end
   end

endmodule

// File: design/haltIrqTracker.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module haltIrqTracker import tracePkg::*; (
   input  logic        rvvi,
   input  logic        reset,
   input  rvfiRecord_t retire,
   input  logic        debugReq,
   output logic        haltReq,
   output logic        haltChanged,
   output irqVec_t     irq,
   output irqVec_t     irqChanged
);

   logic    haltNext;
   irqVec_t irqNext;
   irqVec_t irqDecoded;

   // Halt request
   // Set by debugReq at any time, dropped only at a retire without it
   always_comb begin
      haltNext = haltReq;
      if (debugReq) begin
         haltNext = 1'b1;
      end else if (retire.valid) begin
         haltNext = 1'b0;
      end
   end

   // Interrupt line from the low cause bits
   // Lines that do not exist are masked off
   assign irqDecoded = (irqVec_t'(1) << retire.intr.cause[4:0]) & `IRQ_MASK;

   always_comb begin
      irqNext = irq;
      if (retire.valid) begin
         irqNext = retire.intr.interrupt ? irqDecoded : '0;
      end
   end

   // Levels plus one cycle change markers
   always_ff @(posedge rvvi) begin
      if (reset) begin
         haltReq     <= 1'b0;
         haltChanged <= 1'b0;
         irq         <= '0;
         irqChanged  <= '0;
      end else begin
         haltReq     <= haltNext;
         haltChanged <= haltNext ^ haltReq;
         irq         <= irqNext;
         irqChanged  <= irqNext ^ irq;
      end
   end

endmodule

// File: design/faultTracker.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module faultTracker import tracePkg::*; (
   input  logic        rvvi,
   input  logic        reset,
   input  rvfiRecord_t retire,
   output logic        nmi,
   output intrCause_t  nmiCause,
   output logic        nmiChanged,
   output logic        busFault,
   output logic        busFaultChanged
);

   logic nmiHit;
   logic fetchFault;

   // Data bus error NMI
   // Either taken as an interrupt or still pending at retire
   assign nmiHit = (retire.intr.interrupt &&
                    ((retire.intr.cause == `NMI_LOAD_CAUSE) ||
                     (retire.intr.cause == `NMI_STORE_CAUSE))) ||
                   retire.nmiPending;

   // Instruction fetch bus error
   assign fetchFault = retire.trap.trap && retire.trap.exception &&
                       (retire.trap.excCause == `FETCH_FAULT_CAUSE);

   ////////////////////////////////////////////////////////////////////////////
   // Levels sampled at retire
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (reset) begin
         nmi             <= 1'b0;
         nmiCause        <= '0;
         nmiChanged      <= 1'b0;
         busFault        <= 1'b0;
         busFaultChanged <= 1'b0;
      end else if (retire.valid) begin
         nmi             <= nmiHit;
         nmiChanged      <= nmiHit ^ nmi;
         busFault        <= fetchFault;
         busFaultChanged <= fetchFault ^ busFault;
         // Cause kept from the last retire that raised the NMI
         if (nmiHit) begin
            nmiCause <= retire.intr.cause;
         end
      end else begin
         nmiChanged      <= 1'b0;
         busFaultChanged <= 1'b0;
      end
   end

endmodule

// File: design/traceBridge.sv
`timescale 1ns/1ps

module traceBridge import tracePkg::*; (
   input  logic         rvvi,
   input  logic         reset,
   input  rvfiRecord_t  retire,
   input  csrObsVec_t   csrObs,
   input  logic         debugReq,
   output traceRecord_t trace,
   output csrValueVec_t csrState,
   output csrMask_t     csrWritten,
   output netState_t    nets,
   output netChange_t   netChanged
);

   // Tracker outputs before packing
   logic       haltReq;
   logic       haltChanged;
   irqVec_t    irq;
   irqVec_t    irqChanged;
   logic       nmi;
   intrCause_t nmiCause;
   logic       nmiChanged;
   logic       busFault;
   logic       busFaultChanged;

   ////////////////////////////////////////////////////////////////////////////
   // Units
   ////////////////////////////////////////////////////////////////////////////
   retireCapture capture (
      .rvvi   (rvvi),
      .reset  (reset),
      .retire (retire),
      .trace  (trace)
   );

   csrMerge merge (
      .rvvi       (rvvi),
      .reset      (reset),
      .retire     (retire),
      .csrObs     (csrObs),
      .csrState   (csrState),
      .csrWritten (csrWritten)
   );

   haltIrqTracker haltIrq (
      .rvvi        (rvvi),
      .reset       (reset),
      .retire      (retire),
      .debugReq    (debugReq),
      .haltReq     (haltReq),
      .haltChanged (haltChanged),
      .irq         (irq),
      .irqChanged  (irqChanged)
   );

   faultTracker faults (
      .rvvi            (rvvi),
      .reset           (reset),
      .retire          (retire),
      .nmi             (nmi),
      .nmiCause        (nmiCause),
      .nmiChanged      (nmiChanged),
      .busFault        (busFault),
      .busFaultChanged (busFaultChanged)
   );

   // Net bundles
   assign nets       = '{haltReq, irq, nmi, nmiCause, busFault};
   assign netChanged = '{haltChanged, irqChanged, nmiChanged, busFaultChanged};

endmodule

// File: sim/clockGen.sv
`timescale 1ns/1ps

module clockGen (
   output logic rvvi,
   output logic reset
);

   // 20 ns period, first rising edge at 10 ns
   initial begin
      rvvi = 1'b0;
      forever #10 rvvi = ~rvvi;
   end

   // Reset held for 8 rising edges, released just after the last one
   initial begin
      reset = 1'b1;
      repeat (8) @(posedge rvvi);
      #1 reset = 1'b0;
   end

endmodule

// File: sim/traceBridge_props.sv
`timescale 1ns/1ps

module traceBridgeProps import tracePkg::*; (
   input logic         rvvi,
   input logic         reset,
   input rvfiRecord_t  retire,
   input traceRecord_t trace,
   input csrMask_t     csrWritten,
   input netChange_t   netChanged
);

   // Trace valid is the retire strobe delayed by one cycle
   validFollowsRetire: assert property (@(posedge rvvi) disable iff (reset)
      !$past(reset) |-> (trace.valid == $past(retire.valid)))
      else $error("trace.valid does not follow retire.valid");

   // No CSR write flag without a retire the cycle before
   writtenNeedsRetire: assert property (@(posedge rvvi) disable iff (reset)
      (!$past(reset) && !$past(retire.valid)) |-> (csrWritten == '0))
      else $error("csrWritten set without a preceding retire");

   // Change flags stay quiet in reset
   quietInReset: assert property (@(posedge rvvi)
      (reset && $past(reset)) |-> (netChanged == '0))
      else $error("net change flag set while reset is high");

endmodule

bind traceBridge traceBridgeProps props (
   .rvvi       (rvvi),
   .reset      (reset),
   .retire     (retire),
   .trace      (trace),
   .csrWritten (csrWritten),
   .netChanged (netChanged)
);

// File: sim/traceBridgeTb.sv
`timescale 1ns/1ps
`include "trace_consts.svh"

module traceBridgeTb import tracePkg::*; ();

   logic         rvvi;
   logic         reset;
   rvfiRecord_t  retire;
   csrObsVec_t   csrObs;
   logic         debugReq;
   traceRecord_t trace;
   csrValueVec_t csrState;
   csrMask_t     csrWritten;
   netState_t    nets;
   netChange_t   netChanged;

   integer seed;
   int     cycleCount = 0;
   int     cycleLimit = 1000;

   // Stimulus and expected values, one entry per step
   string        rowName[$];
   rvfiRecord_t  rowRetire[$];
   csrObsVec_t   rowObs[$];
   logic         rowDebug[$];
   traceRecord_t expTrace[$];
   csrValueVec_t expCsr[$];
   csrMask_t     expWritten[$];
   netState_t    expNets[$];
   netChange_t   expChanged[$];

   // Reference model state
   csrValueVec_t mCsr = '0;
   logic         mHalt = 1'b0;
   irqVec_t      mIrq = '0;
   logic         mNmi = 1'b0;
   intrCause_t   mNmiCause = '0;
   logic         mBusFault = 1'b0;

   clockGen clocks (.rvvi(rvvi), .reset(reset));

   traceBridge uut (
      .rvvi       (rvvi),
      .reset      (reset),
      .retire     (retire),
      .csrObs     (csrObs),
      .debugReq   (debugReq),
      .trace      (trace),
      .csrState   (csrState),
      .csrWritten (csrWritten),
      .nets       (nets),
      .netChanged (netChanged)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////
   task automatic compareTrace(input string name, input traceRecord_t exp,
                               input traceRecord_t act);
      if (exp !== act) begin
         $display("[ERROR] %s trace: expected %h, actual %h", name, exp, act);
         $display("sim failed");
         $fatal(1, "trace record mismatch");
      end
   endtask

   task automatic compareCsrValues(input string name, input csrValueVec_t exp,
                                   input csrValueVec_t act);
      if (exp !== act) begin
         $display("[ERROR] %s csrState: expected %h, actual %h", name, exp, act);
         $display("sim failed");
         $fatal(1, "CSR value mismatch");
      end
   endtask

   task automatic compareCsrMask(input string name, input csrMask_t exp,
                                 input csrMask_t act);
      if (exp !== act) begin
         $display("[ERROR] %s csrWritten: expected %h, actual %h", name, exp, act);
         $display("sim failed");
         $fatal(1, "CSR written mask mismatch");
      end
   endtask

   task automatic compareNets(input string name, input netState_t exp,
                              input netState_t act);
      if (exp !== act) begin
         $display("[ERROR] %s nets: expected %h, actual %h", name, exp, act);
         $display("sim failed");
         $fatal(1, "net level mismatch");
      end
   endtask

   task automatic compareNetChange(input string name, input netChange_t exp,
                                   input netChange_t act);
      if (exp !== act) begin
         $display("[ERROR] %s netChanged: expected %h, actual %h", name, exp, act);
         $display("sim failed");
         $fatal(1, "net change flag mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////
   task automatic predictRow(input rvfiRecord_t r, input csrObsVec_t obs,
                             input logic dbg);
      traceRecord_t t;
      csrMask_t     wr;
      netChange_t   c;
      word_t        merged;
      logic         haltNew;
      irqVec_t      irqNew;
      irqVec_t      implemented;
      logic         nmiNew;
      logic         faultNew;
      // Record fields copied every cycle
      t = '0;
      t.valid   = r.valid;
      t.order   = r.order;
      t.insn    = r.insn;
      t.pcRdata = r.pcRdata;
      t.pcWdata = r.pcWdata;
      t.trap    = r.trap;
      t.intr    = r.intr;
      // x0 writes are invisible
      if (r.valid && (r.rdAddr != '0)) begin
         t.regWriteMask = regMask_t'(1) << r.rdAddr;
         t.regWriteData = r.rdData;
      end
      wr = '0;
      if (r.valid) begin
         for (int i = 0; i < `CSR_COUNT; i++) begin
            // Bit by bit, wdata where the mask is set, rdata elsewhere
            for (int b = 0; b < `XLEN; b++) begin
               merged[b] = obs[i].wmask[b] ? obs[i].wdata[b] : obs[i].rdata[b];
            end
            wr[i] = (merged != mCsr[i]);
            mCsr[i] = merged;
         end
      end
      // Halt set by debugReq, cleared by a retire without it
      haltNew = dbg ? 1'b1 : (r.valid ? 1'b0 : mHalt);
      implemented = `IRQ_MASK;
      irqNew = mIrq;
      nmiNew = mNmi;
      faultNew = mBusFault;
      if (r.valid) begin
         // Single line raised only if it exists
         irqNew = '0;
         if (r.intr.interrupt && implemented[r.intr.cause[4:0]]) begin
            irqNew[r.intr.cause[4:0]] = 1'b1;
         end
         nmiNew = r.nmiPending || (r.intr.interrupt &&
                  ((r.intr.cause == `NMI_LOAD_CAUSE) || (r.intr.cause == `NMI_STORE_CAUSE)));
         faultNew = r.trap.trap && r.trap.exception &&
                    (r.trap.excCause == `FETCH_FAULT_CAUSE);
         if (nmiNew) begin
            mNmiCause = r.intr.cause;
         end
      end
      c = '{haltNew ^ mHalt, irqNew ^ mIrq, nmiNew ^ mNmi, faultNew ^ mBusFault};
      mHalt = haltNew;
      mIrq = irqNew;
      mNmi = nmiNew;
      mBusFault = faultNew;
      expTrace.push_back(t);
      expCsr.push_back(mCsr);
      expWritten.push_back(wr);
      expNets.push_back(netState_t'{mHalt, mIrq, mNmi, mNmiCause, mBusFault});
      expChanged.push_back(c);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Table construction
   ////////////////////////////////////////////////////////////////////////////
   function automatic rvfiRecord_t makeRetire(input order_t ord, input word_t pc,
                                              input word_t insn, input regAddr_t rd,
                                              input word_t data);
      rvfiRecord_t r;
      r = '0;
      r.valid   = 1'b1;
      r.order   = ord;
      r.insn    = insn;
      r.pcRdata = pc;
      r.pcWdata = pc + 32'd4;
      r.rdAddr  = rd;
      r.rdData  = data;
      return r;
   endfunction

   // Random read, write and mask data for every slot
   task automatic randomObs(output csrObsVec_t obs);
      for (int i = 0; i < `CSR_COUNT; i++) begin
         obs[i].rdata = $random(seed);
         obs[i].wdata = $random(seed);
         obs[i].wmask = $random(seed);
      end
   endtask

   task automatic addRow(input string name, input rvfiRecord_t r,
                         input csrObsVec_t obs, input logic dbg);
      rowName.push_back(name);
      rowRetire.push_back(r);
      rowObs.push_back(obs);
      rowDebug.push_back(dbg);
      predictRow(r, obs, dbg);
   endtask

   task automatic buildTable();
      csrObsVec_t  obsA;
      csrObsVec_t  obsB;
      rvfiRecord_t r;
      randomObs(obsA);
      randomObs(obsB);
      // Reset and register write mask
      addRow("idle after reset", '0, obsA, 1'b0);
      addRow("retire x0", makeRetire(64'd1, 32'h1000, 32'h0000_0013, 5'd0, 32'h1234), obsA, 1'b0);
      addRow("retire x5", makeRetire(64'd2, 32'h1004, 32'h0050_0293, 5'd5, 32'hDEAD_BEEF),
             obsA, 1'b0);
      // CSR merge under a random mask, then the same data again
      addRow("csr random mask", makeRetire(64'd3, 32'h1008, 32'h3002_9073, 5'd0, '0), obsB, 1'b0);
      addRow("csr same data", makeRetire(64'd4, 32'h100C, 32'h3002_9073, 5'd0, '0), obsB, 1'b0);
      // Halt request
      addRow("debug between retires", '0, obsB, 1'b1);
      addRow("retire under debug", makeRetire(64'd5, 32'h1010, 32'h0000_0013, 5'd0, '0),
             obsB, 1'b1);
      addRow("retire clears halt", makeRetire(64'd6, 32'h1014, 32'h0000_0013, 5'd0, '0),
             obsB, 1'b0);
      // Interrupt lines
      r = makeRetire(64'd7, 32'h1018, 32'h0000_0013, 5'd0, '0);
      r.intr = '{1'b1, 1'b1, 11'd7};
      addRow("timer interrupt", r, obsB, 1'b0);
      r = makeRetire(64'd8, 32'h101C, 32'h0000_0013, 5'd0, '0);
      r.intr = '{1'b1, 1'b1, 11'd5};
      addRow("masked interrupt", r, obsB, 1'b0);
      // Faults
      r = makeRetire(64'd9, 32'h1020, 32'h0000_0013, 5'd0, '0);
      r.intr = '{1'b1, 1'b1, `NMI_LOAD_CAUSE};
      addRow("load error nmi", r, obsB, 1'b0);
      // NMI kept pending so both levels are high together
      r = makeRetire(64'd10, 32'h1024, 32'h0000_0013, 5'd0, '0);
      r.trap = '{1'b1, 1'b1, `FETCH_FAULT_CAUSE};
      r.intr = '{1'b0, 1'b0, `NMI_LOAD_CAUSE};
      r.nmiPending = 1'b1;
      addRow("fetch fault", r, obsB, 1'b0);
      addRow("plain retire", makeRetire(64'd11, 32'h1028, 32'h0000_0013, 5'd1, 32'h55),
             obsB, 1'b0);
      addRow("idle at end", '0, obsB, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Run control
   ////////////////////////////////////////////////////////////////////////////
   // Watchdog on rising edges
   always @(posedge rvvi) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: run did not finish within %0d cycles", cycleLimit);
         $display("sim failed");
         $fatal(1, "simulation timeout");
      end
   end

   initial begin
      seed = 32'hf6aa91d5;
      retire = '0;
      csrObs = '0;
      debugReq = 1'b0;
      buildTable();
      cycleLimit = rowName.size() + 8 + 20;
      @(negedge reset);
      // Inputs change 1 ns after the edge, outputs checked 1 ns after the next
      for (int i = 0; i < rowName.size(); i++) begin
         retire = rowRetire[i];
         csrObs = rowObs[i];
         debugReq = rowDebug[i];
         @(posedge rvvi);
         #1;
         compareTrace(rowName[i], expTrace[i], trace);
         compareCsrValues(rowName[i], expCsr[i], csrState);
         compareCsrMask(rowName[i], expWritten[i], csrWritten);
         compareNets(rowName[i], expNets[i], nets);
         compareNetChange(rowName[i], expChanged[i], netChanged);
      end
      $display("sim passed");
      $finish;
   end

endmodule

// File: all.f
+incdir+design
design/tracePkg.sv
design/retireCapture.sv
design/csrMerge.sv
design/haltIrqTracker.sv
design/faultTracker.sv
design/traceBridge.sv
sim/clockGen.sv
sim/traceBridge_props.sv
sim/traceBridgeTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the trace bridge testbench with Verilator.
# A failing check ends in $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f all.f \
   --top-module traceBridgeTb \
   -o simTraceBridge

./obj_dir/simTraceBridge
